/* source/ifu_consts.svh */
// shared constants of the instruction fetch unit
// bus widths, burst geometry, reset pc and AXI response codes

`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// bus widths
`define IFU_ADDR_WIDTH  32
`define IFU_DATA_WIDTH  32

// burst geometry, slave assumes INCR bursts of this shape
`define IFU_BURST_LEN   4           // beats per burst, 1/2/4/8/16
`define IFU_BEAT_BYTES  4           // bytes per beat

`define IFU_BASE_ADDR   32'h0000_1000   // pc after reset

// AXI response encodings
`define IFU_RESP_OKAY   2'b00
`define IFU_RESP_EXOKAY 2'b01
`define IFU_RESP_SLVERR 2'b10
`define IFU_RESP_DECERR 2'b11

`endif

/* source/ifu_pkg.sv */
// types of the instruction fetch unit
// controller state enum and AXI response enum

`include "ifu_consts.svh"

package ifu_pkg;

    // burst-issue controller states
    typedef enum logic [1:0] {
        fetch_idle,     // nothing in flight
        fetch_req,      // issuing burst_start
        fetch_wait      // burst outstanding
    } fetch_state_e;

    // read response codes as seen on rresp
    typedef enum logic [1:0] {
        resp_okay   = `IFU_RESP_OKAY,
        resp_exokay = `IFU_RESP_EXOKAY,
        resp_slverr = `IFU_RESP_SLVERR,
        resp_decerr = `IFU_RESP_DECERR
    } axi_resp_e;

endpackage

/* source/fetch_ctrl.sv */
// fetch controller
// program counter, burst-issue FSM and sticky fetch error

`timescale 1ns/1ps

`include "ifu_consts.svh"

module fetch_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch_en,
    input  logic                        burst_done,     // last beat transferred
    input  logic                        burst_error,    // valid with burst_done
    output logic                        burst_start,
    output logic [`IFU_ADDR_WIDTH-1:0]  burst_addr,
    output logic                        fetch_error
);

    // bytes covered by one burst
    localparam logic [`IFU_ADDR_WIDTH-1:0] BURST_BYTES =
        `IFU_ADDR_WIDTH'(`IFU_BURST_LEN * `IFU_BEAT_BYTES);

    ifu_pkg::fetch_state_e          state;
    logic [`IFU_ADDR_WIDTH-1:0]     pc;     // start address of next burst

    // ----------------------------------------------------------
    // outputs
    // ----------------------------------------------------------

    // one cycle in fetch_req, so this is a single pulse
    assign burst_start = (state == ifu_pkg::fetch_req);

    // pc only moves on burst_done, so the address holds for the whole burst
    assign burst_addr = pc;

    // ----------------------------------------------------------
    // state machine, pc and error flag
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ifu_pkg::fetch_idle;
            pc          <= `IFU_BASE_ADDR;
            fetch_error <= 1'b0;
        end else begin
            case (state)
                ifu_pkg::fetch_idle: begin
                    if (fetch_en && !fetch_error) begin
                        state <= ifu_pkg::fetch_req;
                    end
                end

                ifu_pkg::fetch_req: begin
                    state <= ifu_pkg::fetch_wait;   // burst_start seen by engine
                end

                ifu_pkg::fetch_wait: begin
                    if (burst_done) begin
                        if (burst_error) begin
                            // stop for good, pc stays on the failing burst
                            fetch_error <= 1'b1;
                            state       <= ifu_pkg::fetch_idle;
                        end else begin
                            pc <= pc + BURST_BYTES;
                            // back-to-back issue while still enabled
                            if (fetch_en) begin
                                state <= ifu_pkg::fetch_req;
                            end else begin
                                state <= ifu_pkg::fetch_idle;
                            end
                        end
                    end
                end

                default: begin
                    state <= ifu_pkg::fetch_idle;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    // the engine only completes the burst this FSM is waiting on
    a_one_burst_in_flight: assert property (
        @(posedge clk) disable iff (!rst_n)
        burst_done |-> (state == ifu_pkg::fetch_wait)
    ) else $error("burst_done arrived while no burst was outstanding");

endmodule

/* source/axi_rd_master.sv */
// AXI4 read channel engine
// AR issue, R beat counting, instruction output and response error tracking

`timescale 1ns/1ps

`include "ifu_consts.svh"

module axi_rd_master (
    input  logic                        clk,
    input  logic                        rst_n,
    // from fetch controller
    input  logic                        burst_start,
    input  logic [`IFU_ADDR_WIDTH-1:0]  burst_addr,
    output logic                        burst_done,
    output logic                        burst_error,
    // AR channel
    output logic [`IFU_ADDR_WIDTH-1:0]  araddr,
    output logic                        arvalid,
    input  logic                        arready,
    // R channel
    input  logic [`IFU_DATA_WIDTH-1:0]  rdata,
    input  logic [1:0]                  rresp,
    input  logic                        rlast,
    input  logic                        rvalid,
    output logic                        rready,
    // instruction stream
    output logic [`IFU_DATA_WIDTH-1:0]  inst,
    output logic [`IFU_ADDR_WIDTH-1:0]  inst_pc,
    output logic                        inst_valid,
    input  logic                        inst_ready
);

    localparam int IDX_W = (`IFU_BURST_LEN > 1) ? $clog2(`IFU_BURST_LEN) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`IFU_BURST_LEN - 1);

    logic [`IFU_ADDR_WIDTH-1:0] base_addr;  // address of beat 0
    logic [IDX_W-1:0]           beat_idx;
    logic                       active;     // burst between start and last beat
    logic                       err_seen;   // earlier beat of this burst failed

    ifu_pkg::axi_resp_e         resp;
    logic                       beat_err;
    logic                       drop;       // consume beat without presenting it
    logic                       beat_xfer;

    // ----------------------------------------------------------
    // AR channel
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
        end else if (burst_start) begin
            arvalid <= 1'b1;
        end else if (arvalid && arready) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (burst_start) begin
            base_addr <= burst_addr;
        end
    end

    assign araddr = base_addr;

    // ----------------------------------------------------------
    // R channel
    // ----------------------------------------------------------

    assign resp     = ifu_pkg::axi_resp_e'(rresp);
    assign beat_err = (resp == ifu_pkg::resp_slverr) || (resp == ifu_pkg::resp_decerr);
    assign drop     = beat_err || err_seen;

    // error beats are swallowed, good beats follow downstream ready
    assign rready     = active && (drop || inst_ready);
    assign inst_valid = active && rvalid && !drop;
    assign inst       = rdata;
    assign inst_pc    = base_addr +
                        (`IFU_ADDR_WIDTH'(beat_idx) * `IFU_ADDR_WIDTH'(`IFU_BEAT_BYTES));

    assign beat_xfer   = active && rvalid && rready;
    assign burst_done  = beat_xfer && rlast;
    assign burst_error = err_seen || beat_err;     // only read with burst_done

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            beat_idx <= '0;
            err_seen <= 1'b0;
        end else if (burst_start) begin
            active   <= 1'b1;
            beat_idx <= '0;
            err_seen <= 1'b0;
        end else if (beat_xfer) begin
            beat_idx <= beat_idx + 1'b1;
            if (beat_err) begin
                err_seen <= 1'b1;
            end
            if (rlast) begin
                active <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    // address must hold until the slave takes it
    a_araddr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (arvalid && !arready) |=> (arvalid && $stable(araddr))
    ) else $error("araddr or arvalid changed before the AR handshake");

    // slave burst length has to match the fixed burst length
    a_rlast_position: assert property (
        @(posedge clk) disable iff (!rst_n)
        beat_xfer |-> (rlast == (beat_idx == LAST_IDX))
    ) else $error("rlast at beat %0d, expected at beat %0d", beat_idx, LAST_IDX);

endmodule

/* source/ifu_top.sv */
// instruction fetch unit top level
// fetch controller plus AXI4 read channel engine

`timescale 1ns/1ps

`include "ifu_consts.svh"

module ifu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch_en,
    // AR channel
    output logic [`IFU_ADDR_WIDTH-1:0]  araddr,
    output logic                        arvalid,
    input  logic                        arready,
    // R channel
    input  logic [`IFU_DATA_WIDTH-1:0]  rdata,
    input  logic [1:0]                  rresp,
    input  logic                        rlast,
    input  logic                        rvalid,
    output logic                        rready,
    // instruction stream
    output logic [`IFU_DATA_WIDTH-1:0]  inst,
    output logic [`IFU_ADDR_WIDTH-1:0]  inst_pc,
    output logic                        inst_valid,
    input  logic                        inst_ready,
    output logic                        fetch_error     // sticky
);

    // controller to engine
    logic                       burst_start;
    logic [`IFU_ADDR_WIDTH-1:0] burst_addr;
    logic                       burst_done;
    logic                       burst_error;

    fetch_ctrl u_fetch_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .burst_done  (burst_done),
        .burst_error (burst_error),
        .burst_start (burst_start),
        .burst_addr  (burst_addr),
        .fetch_error (fetch_error)
    );

    axi_rd_master u_axi_rd_master (
        .clk         (clk),
        .rst_n       (rst_n),
        .burst_start (burst_start),
        .burst_addr  (burst_addr),
        .burst_done  (burst_done),
        .burst_error (burst_error),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_valid  (inst_valid),
        .inst_ready  (inst_ready)
    );

endmodule

/* testbench/ifu_checker.sv */
// monitor and scoreboard of the instruction fetch unit
// reference word function, AR order checks, in-order instruction checks, error counts

`timescale 1ns/1ps

`include "ifu_consts.svh"

module ifu_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`IFU_ADDR_WIDTH-1:0]  araddr,
    input  logic                        arvalid,
    input  logic                        arready,
    input  logic                        rlast,
    input  logic                        rvalid,
    input  logic                        rready,
    input  logic [`IFU_DATA_WIDTH-1:0]  inst,
    input  logic [`IFU_ADDR_WIDTH-1:0]  inst_pc,
    input  logic                        inst_valid,
    input  logic                        inst_ready,
    input  logic                        fetch_error,
    input  logic [`IFU_ADDR_WIDTH-1:0]  err_addr,       // all ones when no error is planted
    output int                          error_count,
    output int                          inst_count,
    output int                          ar_count
);

    localparam logic [31:0] BASE = `IFU_BASE_ADDR;
    localparam logic [31:0] STEP = `IFU_BURST_LEN * `IFU_BEAT_BYTES;

    logic [`IFU_ADDR_WIDTH-1:0] exp_pc;     // next instruction address
    logic [`IFU_ADDR_WIDTH-1:0] exp_ar;     // next burst address
    logic                       burst_open; // AR taken, rlast not yet seen
    logic                       rst_q = 1'b1;

    // memory image the slave serves
    function automatic logic [`IFU_DATA_WIDTH-1:0] word_at(input logic [31:0] addr);
        word_at = {addr[15:0] ^ 16'hA5C3, ~addr[15:0]};
    endfunction

    // pc sits in the planted error burst at or after the failing beat
    function automatic bit in_error_burst(input logic [31:0] pc);
        in_error_burst = (err_addr != 32'hFFFF_FFFF) && (pc >= err_addr) &&
                         ((pc - BASE) / STEP == (err_addr - BASE) / STEP);
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("error: %s expected 0x%h got 0x%h", name, exp, got);
        error_count++;
    endtask

    task automatic rule_error(input string what);
        $display("%s", what);
        error_count++;
    endtask

    initial error_count = 0;

    // ----------------------------------------------------------
    // port checks on every rising edge
    // ----------------------------------------------------------

    always @(posedge clk) begin
        rst_q <= rst_n;
        if (!rst_q) begin  // previous edge applied reset
            if (arvalid !== 1'b0)     rule_error("arvalid is not low after reset");
            if (rready !== 1'b0)      rule_error("rready is not low after reset");
            if (inst_valid !== 1'b0)  rule_error("inst_valid is not low after reset");
            if (fetch_error !== 1'b0) rule_error("fetch_error is not low after reset");
        end
        if (!rst_n) begin
            exp_pc     <= BASE;
            exp_ar     <= BASE;
            burst_open <= 1'b0;
            inst_count <= 0;
            ar_count   <= 0;
        end else begin
            if (arvalid && arready) begin
                if (araddr !== exp_ar) value_error("araddr", exp_ar, araddr);
                if (burst_open)  rule_error("second AR accepted before the previous rlast");
                if (fetch_error) rule_error("AR accepted after fetch_error was set");
                exp_ar     <= exp_ar + STEP;
                burst_open <= 1'b1;
                ar_count   <= ar_count + 1;
            end
            if (rvalid && rready && rlast) burst_open <= 1'b0;
            // good beats hand downstream ready straight back
            if (inst_valid && rready !== inst_ready) begin
                value_error("rready", inst_ready, rready);
            end
            if (inst_valid && inst_ready) begin
                if (inst_pc !== exp_pc) value_error("inst_pc", exp_pc, inst_pc);
                if (inst !== word_at(exp_pc)) value_error("inst", word_at(exp_pc), inst);
                if (in_error_burst(exp_pc)) rule_error("instruction at or after the error beat");
                if (fetch_error) rule_error("instruction delivered after fetch_error was set");
                exp_pc     <= exp_pc + `IFU_BEAT_BYTES;
                inst_count <= inst_count + 1;
            end
        end
    end

endmodule

/* testbench/tb_ifu_top.sv */
// testbench top of the instruction fetch unit
// clock, reset, fetch phases and a behavioral AXI read slave with random delays

`timescale 1ns/1ps

`include "ifu_consts.svh"

module tb_ifu_top;

    localparam int          BL   = `IFU_BURST_LEN;
    localparam logic [31:0] STEP = `IFU_BURST_LEN * `IFU_BEAT_BYTES;

    logic                       clk = 1'b0;
    logic                       rst_n, fetch_en, arready, rlast, rvalid, inst_ready;
    logic                       arvalid, rready, inst_valid, fetch_error;
    logic [`IFU_ADDR_WIDTH-1:0] araddr, inst_pc, err_addr, slave_base;
    logic [`IFU_DATA_WIDTH-1:0] rdata, inst;
    logic [1:0]                 rresp;
    logic                       slave_busy;     // burst accepted, beats pending
    logic                       timed_out;
    int                         slave_beat, slave_gap, last_ar, tb_errors;
    int                         error_count, inst_count, ar_count;
    int unsigned                seed_val;

    always #5 clk = ~clk;

    ifu_top DUT (
        .clk(clk), .rst_n(rst_n), .fetch_en(fetch_en),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
        .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid), .inst_ready(inst_ready),
        .fetch_error(fetch_error)
    );

    ifu_checker u_checker (
        .clk(clk), .rst_n(rst_n), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rlast(rlast), .rvalid(rvalid), .rready(rready), .inst(inst), .inst_pc(inst_pc),
        .inst_valid(inst_valid), .inst_ready(inst_ready), .fetch_error(fetch_error),
        .err_addr(err_addr), .error_count(error_count), .inst_count(inst_count),
        .ar_count(ar_count)
    );

    // downstream back-pressure, ready about three cycles in four
    always @(posedge clk) inst_ready <= rst_n && ($urandom_range(0, 3) != 0);

    // ----------------------------------------------------------
    // AXI read slave, one burst at a time
    // ----------------------------------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rlast      <= 1'b0;
            slave_busy <= 1'b0;
        end else if (!slave_busy) begin
            if (arvalid && arready) begin
                arready    <= 1'b0;
                slave_busy <= 1'b1;
                slave_base <= araddr;
                slave_beat <= 0;
                slave_gap  <= $urandom_range(0, 3);
            end else if (arvalid) begin
                arready <= ($urandom_range(0, 2) == 0);   // random AR wait
            end
        end else if (rvalid && rready) begin
            rvalid     <= 1'b0;
            rlast      <= 1'b0;
            slave_busy <= !rlast;
            slave_beat <= slave_beat + 1;
            slave_gap  <= $urandom_range(0, 2);
        end else if (!rvalid && slave_gap > 0) begin
            slave_gap <= slave_gap - 1;
        end else if (!rvalid) begin
            rvalid <= 1'b1;
            rdata  <= u_checker.word_at(slave_base + 4 * slave_beat);
            rresp  <= (slave_base + 4 * slave_beat == err_addr) ?
                      ifu_pkg::resp_slverr : ifu_pkg::resp_okay;
            rlast  <= (slave_beat == BL - 1);
        end
    end

    task automatic finish_run();
        $display("summary: %0d bursts, %0d instructions, %0d checker errors, %0d tb errors",
                 ar_count, inst_count, error_count, tb_errors);
        if (!timed_out && error_count == 0 && tb_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic expect_value(input string name, input int exp, input int got);
        if (exp != got) begin
            $display("error: %s expected 0x%h got 0x%h", name, exp, got);
            tb_errors++;
        end
    endtask

    task automatic wait_ar_count(input int target);
        int cycles;
        cycles = 0;
        while (ar_count < target && cycles < 8000) begin
            @(posedge clk);
            cycles++;
        end
        if (ar_count < target) begin
            $display("timed out with %0d of %0d bursts issued", ar_count, target);
            timed_out = 1'b1;
        end
    endtask

    // fetch_en already low; let the last burst drain, then expect silence
    task automatic drain_and_check();
        int cycles;
        cycles = 0;
        repeat (3) @(posedge clk);  // covers a burst_start already on its way
        while ((arvalid || slave_busy) && cycles < 300) begin
            @(posedge clk);
            cycles++;
        end
        if (arvalid || slave_busy) begin
            $display("timed out waiting for the current burst to finish");
            timed_out = 1'b1;
        end else begin
            last_ar = ar_count;
            repeat (30) @(posedge clk);
            expect_value("ar_count", last_ar, ar_count);
            expect_value("inst_count", last_ar * BL, inst_count);
        end
    endtask

    task automatic wait_fetch_error();
        int cycles;
        cycles = 0;
        while (!fetch_error && cycles < 500) begin
            @(posedge clk);
            cycles++;
        end
        if (!fetch_error) begin
            $display("timed out waiting for fetch_error after the SLVERR beat");
            timed_out = 1'b1;
        end
    endtask

    task automatic run_phases();
        // stream, pause, resume up to 64 bursts
        fetch_en <= 1'b1;
        wait_ar_count(32);
        if (timed_out) return;
        fetch_en <= 1'b0;
        drain_and_check();
        if (timed_out) return;
        fetch_en <= 1'b1;
        wait_ar_count(64);
        if (timed_out) return;
        fetch_en <= 1'b0;
        drain_and_check();
        if (timed_out) return;

        // SLVERR on the middle beat of the next burst
        err_addr <= `IFU_BASE_ADDR + ar_count * STEP + (BL / 2) * `IFU_BEAT_BYTES;
        fetch_en <= 1'b1;
        wait_fetch_error();
        if (timed_out) return;
        last_ar = ar_count;
        repeat (40) @(posedge clk);
        expect_value("ar_count", last_ar, ar_count);
        expect_value("inst_count", (ar_count - 1) * BL + BL / 2, inst_count);
    endtask

    initial begin
        seed_val = 32'h6beda829;
        void'($urandom(seed_val));
        tb_errors  = 0;
        timed_out  = 1'b0;
        rst_n      = 1'b0;
        fetch_en   = 1'b0;
        inst_ready = 1'b0;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rlast      = 1'b0;
        rresp      = 2'b00;
        rdata      = '0;
        err_addr   = 32'hFFFF_FFFF;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        run_phases();
        finish_run();
    end

endmodule

/* ifu_top.f */
+incdir+source
source/ifu_pkg.sv
source/fetch_ctrl.sv
source/axi_rd_master.sv
source/ifu_top.sv
testbench/ifu_checker.sv
testbench/tb_ifu_top.sv

/* Bender.yml */
package:
  name: ifu_top

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/ifu_pkg.sv
      - source/fetch_ctrl.sv
      - source/axi_rd_master.sv
      - source/ifu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/ifu_checker.sv
      - testbench/tb_ifu_top.sv
